//--- verilog.f
+incdir+hw
hw/rename_pkg.sv
hw/dispatch_sequencer.sv
hw/map_table.sv
hw/reorder_buffer.sv
hw/rename_core.sv
testbench/tb_clock_gen.sv
testbench/rename_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the rename testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module rename_core_tb \
    -f verilog.f \
    -o Vrename_core_tb

./obj_dir/Vrename_core_tb | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
exit 0

//--- testbench/rename_core_tb.sv
// rename core testbench
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_core_tb;
    import rename_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_DISPATCH   = 2000;

    logic          clock;
    logic          rst;
    logic          disp_req;
    dispatch_pkt_t disp_pkt;
    logic          disp_ack;
    rename_rsp_t   disp_rsp;
    cdb_pkt_t      cdb;
    logic          squash;
    retire_pkt_t   retire;

    tb_clock_gen tb_clock_gen_inst (.clock(clock), .rst(rst));

    rename_core rename_core_inst (
        .clock    (clock),
        .rst      (rst),
        .disp_req (disp_req),
        .disp_pkt (disp_pkt),
        .disp_ack (disp_ack),
        .disp_rsp (disp_rsp),
        .cdb      (cdb),
        .squash   (squash),
        .retire   (retire)
    );

    //////////////////////////////////////////////////
    // reference model state
    //////////////////////////////////////////////////
    rob_tag_t              mdl_tag [`REG_COUNT];   // producer per arch reg
    logic [`REG_COUNT-1:0] mdl_rdy;
    rob_tag_t              q_tag  [$];             // rob, oldest at [0]
    reg_idx_t              q_rd   [$];
    logic                  q_wr   [$];
    logic                  q_done [$];
    rob_tag_t              next_tag;               // tag for next dispatch
    logic                  seq_acked;              // expected disp_ack
    rename_rsp_t           exp_rsp;                // captured at dispatch edge

    logic [15:0] lfsr_state;
    int          disp_count;
    int          wait_cycles;   // cycles spent waiting for the current ack

    //////////////////////////////////////////////////
    // failure reporting and compares
    //////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("Finished with errors");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_rsp(input rename_rsp_t got, input rename_rsp_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: disp_rsp got %h expected %h", $time, got, exp);
            abort_run("dispatch response mismatch");
        end
    endtask

    task automatic compare_retire(input retire_pkt_t got, input retire_pkt_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("ERROR %0t: retire got v%b t%0d rd%0d w%b expected v%b t%0d rd%0d w%b",
                     $time, got.valid, got.tag, got.rd, got.writes_rd,
                     exp.valid, exp.tag, exp.rd, exp.writes_rd);
            abort_run("retire mismatch");
        end
    endtask

    task automatic compare_ack(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: disp_ack got %b expected %b", $time, got, exp);
            abort_run("handshake mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // random source, 16-bit fibonacci lfsr
    //////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[14:0], lfsr_state[0]};
        end
    endtask

    // half the time a low register, so dependencies are common
    task automatic pick_reg(output reg_idx_t r);
        logic [15:0] b;
        take_bits(1, b);
        if (b[0]) begin
            take_bits(3, b);
            r = reg_idx_t'(b[2:0]);
        end else begin
            take_bits(5, b);
            r = reg_idx_t'(b[4:0]);
        end
    endtask

    //////////////////////////////////////////////////
    // model rules
    //////////////////////////////////////////////////
    task automatic reset_model;
        for (int i = 0; i < `REG_COUNT; i++) begin
            mdl_tag[i] = '0;
        end
        mdl_rdy = '0;
        q_tag.delete();
        q_rd.delete();
        q_wr.delete();
        q_done.delete();
        next_tag = rob_tag_t'(1);
    endtask

    function automatic logic head_retires();
        return (q_tag.size() > 0) && q_done[0];
    endfunction

    // source view before this dispatch's rd write, same-cycle cdb and retire folded in
    function automatic operand_info_t expect_src(input reg_idx_t r);
        operand_info_t o;
        o = '0;
        if (r != '0 && mdl_tag[r] != '0) begin
            if (!(head_retires() && q_wr[0] && q_rd[0] == r && q_tag[0] == mdl_tag[r])) begin
                o.tag   = mdl_tag[r];
                o.ready = mdl_rdy[r] || (cdb.valid && cdb.tag == mdl_tag[r]);
            end
        end
        return o;
    endfunction

    always @(posedge clock) begin : model_update
        logic     ret_now;
        logic     disp_now;
        rob_tag_t ret_tag;
        reg_idx_t ret_rd;
        logic     ret_wr;
        if (rst) begin
            reset_model();
            seq_acked = 1'b0;
        end else begin
            ret_now  = head_retires();
            ret_tag  = ret_now ? q_tag[0] : '0;
            ret_rd   = ret_now ? q_rd[0] : '0;
            ret_wr   = ret_now ? q_wr[0] : 1'b0;
            disp_now = !seq_acked && disp_req && (q_tag.size() < `ROB_DEPTH) && !squash;
            if (disp_now) begin
                exp_rsp.dest_tag = next_tag;
                exp_rsp.src[0]   = expect_src(disp_pkt.rs1);
                exp_rsp.src[1]   = expect_src(disp_pkt.rs2);
            end
            if (squash) begin
                reset_model();  // full flush
            end else begin
                // per register: new producer, else commit clear, else wakeup
                for (int i = 1; i < `REG_COUNT; i++) begin
                    if (disp_now && disp_pkt.writes_rd && disp_pkt.rd == reg_idx_t'(i)) begin
                        mdl_tag[i] = next_tag;
                        mdl_rdy[i] = 1'b0;
                    end else if (ret_now && ret_wr && ret_rd == reg_idx_t'(i) &&
                                 mdl_tag[i] == ret_tag) begin
                        mdl_tag[i] = '0;
                        mdl_rdy[i] = 1'b0;
                    end else if (cdb.valid && mdl_tag[i] != '0 && mdl_tag[i] == cdb.tag) begin
                        mdl_rdy[i] = 1'b1;
                    end
                end
                for (int i = 0; i < q_tag.size(); i++) begin
                    if (cdb.valid && q_tag[i] == cdb.tag) begin
                        q_done[i] = 1'b1;
                    end
                end
                if (ret_now) begin
                    void'(q_tag.pop_front());
                    void'(q_rd.pop_front());
                    void'(q_wr.pop_front());
                    void'(q_done.pop_front());
                end
                if (disp_now) begin
                    q_tag.push_back(next_tag);
                    q_rd.push_back(disp_pkt.rd);
                    q_wr.push_back(disp_pkt.writes_rd);
                    q_done.push_back(1'b0);
                    next_tag = (next_tag == rob_tag_t'(`ROB_DEPTH)) ?
                               rob_tag_t'(1) : next_tag + rob_tag_t'(1);
                end
            end
            if (disp_now) begin
                seq_acked = 1'b1;
            end else if (!disp_req) begin
                seq_acked = 1'b0;   // ack drops once req is seen low
            end
        end
    end

    //////////////////////////////////////////////////
    // per-cycle checks and strobes
    //////////////////////////////////////////////////
    // windows with no completions so the rob fills up
    function automatic logic quiet_window();
        return (disp_count % 100) >= 50 && (disp_count % 100) < 62;
    endfunction

    task automatic tick;
        retire_pkt_t exp_ret;
        logic [15:0] b;
        logic        allow;
        int          pend [$];
        int          sel;
        @(negedge clock);
        exp_ret = '0;
        if (head_retires()) begin
            exp_ret.valid     = 1'b1;
            exp_ret.tag       = q_tag[0];
            exp_ret.rd        = q_rd[0];
            exp_ret.writes_rd = q_wr[0];
        end
        compare_retire(retire, exp_ret);
        compare_ack(disp_ack, seq_acked);
        if (seq_acked) begin
            compare_rsp(disp_rsp, exp_rsp);     // held until next dispatch
        end
        allow = !quiet_window() || wait_cycles >= 16;   // quiet ends if stalled long
        take_bits(7, b);
        squash = allow && (b[6:0] == 7'd0);     // rare flush
        cdb    = '0;
        if (!squash && allow) begin
            for (int i = 0; i < q_tag.size(); i++) begin
                if (!q_done[i]) begin
                    pend.push_back(i);
                end
            end
            take_bits(2, b);
            if (pend.size() > 0 && b[1:0] != 2'd0) begin
                take_bits(4, b);
                sel       = int'(b[3:0]) % pend.size();
                cdb.valid = 1'b1;
                cdb.tag   = q_tag[pend[sel]];  // any pending entry, not only head
            end
        end
    endtask

    // one four-phase dispatch with random operands
    task automatic run_dispatch;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [15:0] b;
        int          n;
        pick_reg(rd);
        pick_reg(rs1);
        pick_reg(rs2);
        take_bits(2, b);
        disp_pkt.rd        = rd;
        disp_pkt.rs1       = rs1;
        disp_pkt.rs2       = rs2;
        disp_pkt.writes_rd = (b[1:0] != 2'd0);
        disp_req           = 1'b1;
        n = 0;
        do begin
            wait_cycles = n;
            tick();
            n++;
            if (n > TIMEOUT_CYCLES) begin
                $display("timeout at %0t: disp_ack never rose after the request", $time);
                abort_run("dispatch acknowledge timed out");
            end
        end while (!disp_ack);
        disp_req = 1'b0;
        n = 0;
        do begin
            wait_cycles = 0;
            tick();
            n++;
            if (n > TIMEOUT_CYCLES) begin
                $display("timeout at %0t: disp_ack stayed high after the request dropped",
                         $time);
                abort_run("acknowledge release timed out");
            end
        end while (disp_ack);
        disp_count++;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin : stimulus
        logic [15:0] b;
        int          n;
        lfsr_state  = 16'd42533;
        disp_req    = 1'b0;
        disp_pkt    = '0;
        cdb         = '0;
        squash      = 1'b0;
        disp_count  = 0;
        wait_cycles = 0;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (n > TIMEOUT_CYCLES) begin
                $display("timeout: reset was never released");
                abort_run("reset release timed out");
            end
        end while (rst !== 1'b0);
        while (disp_count < NUM_DISPATCH) begin
            wait_cycles = 0;
            tick();
            take_bits(2, b);
            if (b[1:0] != 2'd0) begin   // idle gap otherwise
                run_dispatch();
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst
);
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;     // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clock);   // 16 cycles in reset
        @(negedge clock);
        rst = 1'b0;                     // released on the drive edge
    end
endmodule

`default_nettype wire

//--- hw/rename_core.sv
// rename and retire top
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  logic                      clock,
    input  logic                      rst,
    // dispatch, four-phase req/ack
    input  logic                      disp_req,
    input  rename_pkg::dispatch_pkt_t disp_pkt,
    output logic                      disp_ack,
    output rename_pkg::rename_rsp_t   disp_rsp,
    // completion and flush strobes
    input  rename_pkg::cdb_pkt_t      cdb,
    input  logic                      squash,
    // commit
    output rename_pkg::retire_pkt_t   retire
);
    import rename_pkg::*;

    //////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////
    logic          alloc;       // one-cycle dispatch strobe
    dispatch_pkt_t alloc_pkt;
    rob_tag_t      alloc_tag;   // rob tail
    logic          full;
    rename_rsp_t   lookup;      // combinational source read

    dispatch_sequencer dispatch_sequencer_inst (
        .clock     (clock),
        .rst       (rst),
        .disp_req  (disp_req),
        .disp_pkt  (disp_pkt),
        .full      (full),
        .squash    (squash),
        .alloc     (alloc),
        .alloc_pkt (alloc_pkt),
        .alloc_tag (alloc_tag),
        .lookup    (lookup),
        .disp_ack  (disp_ack),
        .disp_rsp  (disp_rsp)
    );

    map_table map_table_inst (
        .clock     (clock),
        .rst       (rst),
        .squash    (squash),
        .alloc     (alloc),
        .alloc_pkt (alloc_pkt),
        .alloc_tag (alloc_tag),
        .cdb       (cdb),
        .retire    (retire),    // clears committed mappings
        .lookup    (lookup)
    );

    reorder_buffer reorder_buffer_inst (
        .clock     (clock),
        .rst       (rst),
        .squash    (squash),
        .alloc     (alloc),
        .alloc_pkt (alloc_pkt),
        .alloc_tag (alloc_tag),
        .full      (full),
        .cdb       (cdb),
        .retire    (retire)
    );

endmodule

`default_nettype wire

//--- hw/reorder_buffer.sv
// reorder buffer
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module reorder_buffer (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      squash,
    input  logic                      alloc,
    input  rename_pkg::dispatch_pkt_t alloc_pkt,
    output rename_pkg::rob_tag_t      alloc_tag,
    output logic                      full,
    input  rename_pkg::cdb_pkt_t      cdb,
    output rename_pkg::retire_pkt_t   retire
);
    import rename_pkg::*;

    localparam int IDX_W = `ROB_TAG_W - 1;     // tag drops the reserved zero

    typedef logic [IDX_W-1:0]      rob_idx_t;
    typedef logic [`ROB_TAG_W-1:0] rob_cnt_t;  // 0..ROB_DEPTH

    //////////////////////////////////////////////////
    // entry storage
    //////////////////////////////////////////////////
    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] complete;
    reg_idx_t              ent_rd        [`ROB_DEPTH];     // payload
    logic [`ROB_DEPTH-1:0] ent_writes_rd;                  // payload

    rob_idx_t head;     // oldest
    rob_idx_t tail;     // next free
    rob_cnt_t count;

    rob_idx_t cdb_idx;

    // circular increment, depth need not be a power of two
    function automatic rob_idx_t next_ptr(input rob_idx_t p);
        rob_idx_t n;
        if (p == rob_idx_t'(`ROB_DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + rob_idx_t'(1);
        end
        return n;
    endfunction

    // tag = index + 1
    function automatic rob_tag_t idx_to_tag(input rob_idx_t i);
        return rob_tag_t'(i) + rob_tag_t'(1);
    endfunction

    assign cdb_idx   = rob_idx_t'(cdb.tag - rob_tag_t'(1));
    assign alloc_tag = idx_to_tag(tail);
    assign full      = (count == rob_cnt_t'(`ROB_DEPTH));

    //////////////////////////////////////////////////
    // in-order retire, combinational from head
    //////////////////////////////////////////////////
    always_comb begin
        retire.valid     = busy[head] && complete[head];
        retire.tag       = idx_to_tag(head);
        retire.rd        = ent_rd[head];
        retire.writes_rd = ent_writes_rd[head];
    end

    //////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst || squash) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            busy     <= '0;
            complete <= '0;
        end else begin
            if (alloc) begin
                busy[tail]     <= 1'b1;
                complete[tail] <= 1'b0;
                tail           <= next_ptr(tail);
            end
            if (cdb.valid) begin
                complete[cdb_idx] <= 1'b1;  // result broadcast
            end
            // head never equals tail while both busy and allocating
            if (retire.valid) begin
                busy[head]     <= 1'b0;
                complete[head] <= 1'b0;
                head           <= next_ptr(head);
            end
            case ({alloc, retire.valid})
                2'b10:   count <= count + rob_cnt_t'(1);
                2'b01:   count <= count - rob_cnt_t'(1);
                default: count <= count;    // none, or one in and one out
            endcase
        end
    end

    // entry payload, written on allocation only
    always_ff @(posedge clock) begin
        if (alloc) begin
            ent_rd[tail]        <= alloc_pkt.rd;
            ent_writes_rd[tail] <= alloc_pkt.writes_rd;
        end
    end

    // completion must target a live, still pending entry
    a_cdb_live: assert property (@(posedge clock) disable iff (rst)
        cdb.valid |-> (busy[cdb_idx] && !complete[cdb_idx]));

    a_no_alloc_full: assert property (@(posedge clock) disable iff (rst)
        alloc |-> !full);

endmodule

`default_nettype wire

//--- hw/map_table.sv
// register map table
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module map_table (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      squash,
    input  logic                      alloc,
    input  rename_pkg::dispatch_pkt_t alloc_pkt,
    input  rename_pkg::rob_tag_t      alloc_tag,
    input  rename_pkg::cdb_pkt_t      cdb,
    input  rename_pkg::retire_pkt_t   retire,
    output rename_pkg::rename_rsp_t   lookup
);
    import rename_pkg::*;

    rob_tag_t               map_tag [`REG_COUNT];   // producer per arch reg
    logic [`REG_COUNT-1:0]  map_rdy;                // producer has broadcast

    //////////////////////////////////////////////////
    // source lookup
    //////////////////////////////////////////////////
    // view of the map before this dispatch's own rd write,
    // with this cycle's retire clear and cdb wakeup folded in
    function automatic operand_info_t read_src(input reg_idx_t r);
        operand_info_t info;
        info.tag   = map_tag[r];
        info.ready = map_rdy[r];
        if (r == '0 || info.tag == '0) begin
            info = '0;              // x0 or arch value, read regfile
        end else if (retire.valid && retire.writes_rd && retire.rd == r &&
                     retire.tag == info.tag) begin
            info = '0;              // being committed this cycle
        end else if (cdb.valid && cdb.tag == info.tag) begin
            info.ready = 1'b1;      // bypass same-cycle wakeup
        end
        return info;
    endfunction

    always_comb begin
        lookup.dest_tag = alloc_tag;
        lookup.src[0]   = read_src(alloc_pkt.rs1);
        lookup.src[1]   = read_src(alloc_pkt.rs2);
    end

    //////////////////////////////////////////////////
    // map update
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst || squash) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                map_tag[i] <= '0;   // everything back in the regfile
            end
            map_rdy <= '0;
        end else begin
            for (int i = 1; i < `REG_COUNT; i++) begin    // x0 never renamed
                if (alloc && alloc_pkt.writes_rd && alloc_pkt.rd == reg_idx_t'(i)) begin
                    map_tag[i] <= alloc_tag;    // new producer
                    map_rdy[i] <= 1'b0;
                end else if (retire.valid && retire.writes_rd &&
                             retire.rd == reg_idx_t'(i) && retire.tag == map_tag[i]) begin
                    // only if no younger producer took over
                    map_tag[i] <= '0;
                    map_rdy[i] <= 1'b0;
                end else if (cdb.valid && map_tag[i] != '0 && map_tag[i] == cdb.tag) begin
                    map_rdy[i] <= 1'b1;         // wakeup
                end
            end
        end
    end

    // sequencer blocks dispatch on squash
    a_no_alloc_squash: assert property (@(posedge clock) disable iff (rst)
        !(alloc && squash));

    // tag 0 would wake every regfile entry
    a_cdb_nonzero: assert property (@(posedge clock) disable iff (rst)
        cdb.valid |-> (cdb.tag != '0));

endmodule

`default_nettype wire

//--- hw/dispatch_sequencer.sv
// dispatch handshake sequencer
`timescale 1ns/1ps
`default_nettype none

module dispatch_sequencer (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    disp_req,
    input  rename_pkg::dispatch_pkt_t disp_pkt,
    input  logic                    full,
    input  logic                    squash,
    output logic                    alloc,
    output rename_pkg::dispatch_pkt_t alloc_pkt,
    input  rename_pkg::rob_tag_t    alloc_tag,
    input  rename_pkg::rename_rsp_t lookup,     // only src is meaningful here
    output logic                    disp_ack,
    output rename_pkg::rename_rsp_t disp_rsp
);
    import rename_pkg::*;

    seq_state_t state;

    // admissible request lasts one cycle since state leaves IDLE at once
    assign alloc     = (state == IDLE) && disp_req && !full && !squash;
    assign alloc_pkt = disp_pkt;    // packet is held stable by the source

    //////////////////////////////////////////////////
    // four-phase handshake
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= IDLE;
            disp_ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (alloc) begin
                        state    <= ALLOC;
                        disp_ack <= 1'b1;   // ack with response next cycle
                    end
                end
                ALLOC, WAIT_DROP: begin
                    // source may already drop req in the first ack cycle
                    if (!disp_req) begin
                        state    <= IDLE;
                        disp_ack <= 1'b0;
                    end else begin
                        state <= WAIT_DROP;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // response captured on the dispatch edge
    always_ff @(posedge clock) begin
        if (alloc) begin
            disp_rsp.dest_tag <= alloc_tag;
            disp_rsp.src      <= lookup.src;
        end
    end

    // a waiting request keeps req and packet until it is taken
    a_req_held: assert property (@(posedge clock) disable iff (rst)
        (disp_req && !disp_ack && !alloc) |=> (disp_req && $stable(disp_pkt)));

    // new request only once the previous ack is low
    a_req_after_drop: assert property (@(posedge clock) disable iff (rst)
        $rose(disp_req) |-> !disp_ack);

endmodule

`default_nettype wire

//--- hw/rename_pkg.sv
// rename types
`default_nettype none

`include "rename_consts.svh"

package rename_pkg;

    //////////////////////////////////////////////////
    // plain widths
    //////////////////////////////////////////////////
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;   // architectural register
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;   // 1..ROB_DEPTH, 0 = regfile

    //////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////
    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     writes_rd;    // low for stores, branches
    } dispatch_pkt_t;

    typedef struct packed {
        rob_tag_t tag;          // producer, or 0
        logic     ready;        // producer already broadcast
    } operand_info_t;

    typedef struct packed {
        rob_tag_t              dest_tag;
        operand_info_t [1:0]   src;     // [0] rs1, [1] rs2
    } rename_rsp_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } cdb_pkt_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t rd;
        logic     writes_rd;
    } retire_pkt_t;

    // dispatch handshake fsm
    typedef enum logic [1:0] {
        IDLE,
        WAIT_DROP,
        ALLOC
    } seq_state_t;

endpackage

`default_nettype wire

//--- hw/rename_consts.svh
// rename block constants
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

//////////////////////////////////////////////////
// architectural register file
//////////////////////////////////////////////////
`define REG_COUNT 32     // x0..x31
`define REG_IDX_W 5      // log2 of REG_COUNT

//////////////////////////////////////////////////
// reorder buffer
//////////////////////////////////////////////////
`define ROB_DEPTH 8      // entries in flight

// one bit wider than the index
// tag 0 is reserved for "value sits in the register file"
`define ROB_TAG_W 4

`endif
